/* hw/vga_pkg.sv */
package vga_pkg;

  // Pixel color, RRRGGGBB
  localparam int unsigned COLOR_W = 8;

  // Word index comes from address bits 3:2
  localparam int unsigned REG_IDX_LSB = 2;
  localparam int unsigned REG_IDX_W   = 2;

  localparam logic [REG_IDX_W-1:0] REG_CTRL   = 2'd0; // Enable, prescaler, resolution, mode
  localparam logic [REG_IDX_W-1:0] REG_COLOR  = 2'd1; // Both fill colors
  localparam logic [REG_IDX_W-1:0] REG_STATUS = 2'd2; // Read only
  // Index 3 is unmapped and reads zero

  // CTRL layout
  localparam int unsigned CTRL_EN_BIT    = 0;
  localparam int unsigned CTRL_PRESC_LSB = 4;
  localparam int unsigned CTRL_RES_LSB   = 8;
  localparam int unsigned CTRL_MODE_BIT  = 12; // 0 fill, 1 checkerboard

  // Field widths shared by all blocks
  localparam int unsigned PRESC_W = 4; // Strobe every prescaler+1 clocks
  localparam int unsigned RES_W   = 2; // Coordinate right shift

  // Largest legal shift, 3 is clamped to this
  localparam logic [RES_W-1:0] RES_MAX = 2'd2;

  // COLOR layout
  localparam int unsigned COLOR0_LSB = 0;
  localparam int unsigned COLOR1_LSB = 8;

  // STATUS layout
  localparam int unsigned STAT_VBLANK_BIT = 0;
  localparam int unsigned STAT_FRAME_LSB  = 16;
  localparam int unsigned FRAME_W         = 16; // Frame count wraps at 2**16

  // Position counters
  localparam int unsigned CNT_W = 11;

  // Coordinate bit that sets the checker cell size
  localparam int unsigned CHECK_BIT = 1;

endpackage

/* hw/vga_wb_regs.sv */
`timescale 1ns/10ps

module vga_wb_regs (
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  // Wishbone classic slave
  input  logic                        wbs_cyc_i,
  input  logic                        wbs_stb_i,
  input  logic                        wbs_we_i,
  input  logic [3:0]                  wbs_sel_i,
  input  logic [31:0]                 wbs_adr_i,
  input  logic [31:0]                 wbs_dat_i,
  output logic                        wbs_ack_o,
  output logic [31:0]                 wbs_dat_o,
  // Status from the timing generator
  input  logic                        vblank_i,
  input  logic [vga_pkg::FRAME_W-1:0] frame_cnt_i,
  // Control to the video blocks
  output logic                        enable_o,
  output logic [vga_pkg::PRESC_W-1:0] presc_o,
  output logic [vga_pkg::RES_W-1:0]   res_shift_o,
  output logic                        mode_o,
  output logic [vga_pkg::COLOR_W-1:0] color0_o,
  output logic [vga_pkg::COLOR_W-1:0] color1_o
);
  import vga_pkg::*;

  logic [REG_IDX_W-1:0] reg_idx;  // Word index of the current transfer
  logic                 req;      // Transfer sampled this cycle
  logic                 wr_en;    // Write commits on this edge
  logic [RES_W-1:0]     res_q;    // Resolution field as written
  logic [31:0]          rd_data;  // Read mux, before ack gating

  assign reg_idx = wbs_adr_i[REG_IDX_LSB +: REG_IDX_W];
  assign req     = wbs_cyc_i && wbs_stb_i && !wbs_ack_o; // No new request during ack
  assign wr_en   = req && wbs_we_i;

  // Single cycle ack, one clock after the request is seen
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wbs_ack_o <= 1'b0;
    end else begin
      wbs_ack_o <= req;
    end
  end

  // CTRL, byte lanes follow sel
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      enable_o <= 1'b0; // Display starts off
      presc_o  <= '0;
      res_q    <= '0;
      mode_o   <= 1'b0;
    end else if (wr_en && reg_idx == REG_CTRL) begin
      if (wbs_sel_i[CTRL_EN_BIT/8])    enable_o <= wbs_dat_i[CTRL_EN_BIT];
      if (wbs_sel_i[CTRL_PRESC_LSB/8]) presc_o  <= wbs_dat_i[CTRL_PRESC_LSB +: PRESC_W];
      if (wbs_sel_i[CTRL_RES_LSB/8])   res_q    <= wbs_dat_i[CTRL_RES_LSB +: RES_W];
      if (wbs_sel_i[CTRL_MODE_BIT/8])  mode_o   <= wbs_dat_i[CTRL_MODE_BIT];
    end
  end

  // COLOR, one byte per color
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      color0_o <= '0;
      color1_o <= '0;
    end else if (wr_en && reg_idx == REG_COLOR) begin
      if (wbs_sel_i[COLOR0_LSB/8]) color0_o <= wbs_dat_i[COLOR0_LSB +: COLOR_W];
      if (wbs_sel_i[COLOR1_LSB/8]) color1_o <= wbs_dat_i[COLOR1_LSB +: COLOR_W];
    end
  end

  // Shift of 3 behaves as 2, readback shows the clamped value
  assign res_shift_o = (res_q > RES_MAX) ? RES_MAX : res_q;

  always_comb begin
    rd_data = '0;
    case (reg_idx)
      REG_CTRL: begin
        rd_data[CTRL_EN_BIT]               = enable_o;
        rd_data[CTRL_PRESC_LSB +: PRESC_W] = presc_o;
        rd_data[CTRL_RES_LSB +: RES_W]     = res_shift_o;
        rd_data[CTRL_MODE_BIT]             = mode_o;
      end
      REG_COLOR: begin
        rd_data[COLOR0_LSB +: COLOR_W] = color0_o;
        rd_data[COLOR1_LSB +: COLOR_W] = color1_o;
      end
      REG_STATUS: begin
        rd_data[STAT_VBLANK_BIT]           = vblank_i;
        rd_data[STAT_FRAME_LSB +: FRAME_W] = frame_cnt_i;
      end
      default: ; // Unmapped word reads zero
    endcase
  end

  // Address is still held by the master while ack is high
  assign wbs_dat_o = wbs_ack_o ? rd_data : '0;

  // Ack is a one cycle pulse
  a_ack_pulse : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wbs_ack_o |=> !wbs_ack_o)
    else $error("ack high for two cycles");

  // Ack answers a request from the cycle before
  a_ack_req : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wbs_ack_o |-> $past(wbs_cyc_i && wbs_stb_i))
    else $error("ack without a preceding request");

endmodule

/* hw/vga_timing.sv */
`timescale 1ns/10ps

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FPORCH = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BPORCH = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FPORCH = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BPORCH = 33
) (
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  input  logic                        enable_i,
  input  logic [vga_pkg::PRESC_W-1:0] presc_i,
  input  logic [vga_pkg::RES_W-1:0]   res_shift_i,
  output logic                        active_o,
  output logic [vga_pkg::CNT_W-1:0]   x_o,
  output logic [vga_pkg::CNT_W-1:0]   y_o,
  output logic                        hsync_n_o,
  output logic                        vsync_n_o,
  output logic                        vblank_o,
  output logic [vga_pkg::FRAME_W-1:0] frame_cnt_o
);
  import vga_pkg::*;

  // Segment boundaries at base resolution
  localparam int H_TOTAL      = H_ACTIVE + H_FPORCH + H_SYNC + H_BPORCH;
  localparam int H_SYNC_START = H_ACTIVE + H_FPORCH;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_TOTAL      = V_ACTIVE + V_FPORCH + V_SYNC + V_BPORCH;
  localparam int V_SYNC_START = V_ACTIVE + V_FPORCH;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  logic [PRESC_W-1:0] presc_cnt;  // Clocks since last strobe
  logic [CNT_W-1:0]   h_cnt;      // Base horizontal position
  logic [CNT_W-1:0]   v_cnt;      // Base vertical position
  logic               pix_stb;    // One pixel step
  logic               line_end;
  logic               frame_end;
  logic               h_vis;
  logic               v_vis;
  logic               h_in_sync;
  logic               v_in_sync;

  // >= so that lowering the prescaler mid count never stalls
  assign pix_stb   = enable_i && (presc_cnt >= presc_i);
  assign line_end  = (h_cnt == CNT_W'(H_TOTAL - 1));
  assign frame_end = (v_cnt == CNT_W'(V_TOTAL - 1));

  // Prescaler, held at zero while disabled
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      presc_cnt <= '0;
    end else if (!enable_i || pix_stb) begin
      presc_cnt <= '0;
    end else begin
      presc_cnt <= presc_cnt + 1'b1;
    end
  end

  // Position counters
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!enable_i) begin
      h_cnt <= '0; // Restart from the top left on next enable
      v_cnt <= '0;
    end else if (pix_stb) begin
      if (line_end) begin
        h_cnt <= '0;
        v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Completed frames, free running across disable
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      frame_cnt_o <= '0;
    end else if (pix_stb && line_end && frame_end) begin
      frame_cnt_o <= frame_cnt_o + 1'b1; // Wraps naturally
    end
  end

  // Segment decode
  assign h_vis     = (h_cnt < CNT_W'(H_ACTIVE));
  assign v_vis     = (v_cnt < CNT_W'(V_ACTIVE));
  assign h_in_sync = (h_cnt >= CNT_W'(H_SYNC_START)) && (h_cnt < CNT_W'(H_SYNC_END));
  assign v_in_sync = (v_cnt >= CNT_W'(V_SYNC_START)) && (v_cnt < CNT_W'(V_SYNC_END));

  assign active_o  = h_vis && v_vis;
  assign hsync_n_o = !h_in_sync; // Sync is active low
  assign vsync_n_o = !v_in_sync;
  assign vblank_o  = !v_vis;

  // Scaled coordinates for the pixel stage
  assign x_o = h_cnt >> res_shift_i;
  assign y_o = v_cnt >> res_shift_i;

  // Counters never leave their frame
  a_h_range : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    h_cnt < CNT_W'(H_TOTAL))
    else $error("horizontal counter past line total");

  a_v_range : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    v_cnt < CNT_W'(V_TOTAL))
    else $error("vertical counter past frame total");

endmodule

/* hw/vga_pixel_out.sv */
`timescale 1ns/10ps

module vga_pixel_out (
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  input  logic                        enable_i,
  input  logic                        mode_i,    // 0 fill, 1 checker
  input  logic [vga_pkg::COLOR_W-1:0] color0_i,
  input  logic [vga_pkg::COLOR_W-1:0] color1_i,
  input  logic                        active_i,
  input  logic [vga_pkg::CNT_W-1:0]   x_i,       // Scaled coordinates
  input  logic [vga_pkg::CNT_W-1:0]   y_i,
  input  logic                        hsync_n_i,
  input  logic                        vsync_n_i,
  output logic [vga_pkg::COLOR_W-1:0] pixel_o,
  output logic                        hsync_o,
  output logic                        vsync_o
);
  import vga_pkg::*;

  logic               cell_odd;   // Checker cell takes color1
  logic [COLOR_W-1:0] pix_next;   // Color for the current position

  assign cell_odd = x_i[CHECK_BIT] ^ y_i[CHECK_BIT];

  // Pattern select
  always_comb begin
    if (!active_i) begin
      pix_next = '0; // Black in porches and sync
    end else if (mode_i && cell_odd) begin
      pix_next = color1_i;
    end else begin
      pix_next = color0_i;
    end
  end

  // Pixel and syncs leave together, one clock after the counters
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      pixel_o <= '0;
      hsync_o <= 1'b1; // Idle high
      vsync_o <= 1'b1;
    end else if (!enable_i) begin
      pixel_o <= '0;
      hsync_o <= 1'b1;
      vsync_o <= 1'b1;
    end else begin
      pixel_o <= pix_next;
      hsync_o <= hsync_n_i;
      vsync_o <= vsync_n_i;
    end
  end

endmodule

/* hw/vga_top.sv */
`timescale 1ns/10ps

module vga_top #(
  parameter int H_ACTIVE = 640,
  parameter int H_FPORCH = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BPORCH = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FPORCH = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BPORCH = 33
) (
  input  logic                        wb_clk_i,
  input  logic                        wb_rst_i,
  // Wishbone slave
  input  logic                        wbs_cyc_i,
  input  logic                        wbs_stb_i,
  input  logic                        wbs_we_i,
  input  logic [3:0]                  wbs_sel_i,
  input  logic [31:0]                 wbs_adr_i,
  input  logic [31:0]                 wbs_dat_i,
  output logic                        wbs_ack_o,
  output logic [31:0]                 wbs_dat_o,
  // Video
  output logic [vga_pkg::COLOR_W-1:0] pixel_o,
  output logic                        hsync_o,
  output logic                        vsync_o
);
  import vga_pkg::*;

  // Register block to video
  logic               enable;
  logic [PRESC_W-1:0] presc;
  logic [RES_W-1:0]   res_shift;
  logic               mode;
  logic [COLOR_W-1:0] color0;
  logic [COLOR_W-1:0] color1;

  // Timing to pixel stage and status
  logic               active;
  logic [CNT_W-1:0]   x;
  logic [CNT_W-1:0]   y;
  logic               hsync_n;
  logic               vsync_n;
  logic               vblank;
  logic [FRAME_W-1:0] frame_cnt;

  vga_wb_regs vga_wb_regs_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wbs_cyc_i   (wbs_cyc_i),
    .wbs_stb_i   (wbs_stb_i),
    .wbs_we_i    (wbs_we_i),
    .wbs_sel_i   (wbs_sel_i),
    .wbs_adr_i   (wbs_adr_i),
    .wbs_dat_i   (wbs_dat_i),
    .wbs_ack_o   (wbs_ack_o),
    .wbs_dat_o   (wbs_dat_o),
    .vblank_i    (vblank),
    .frame_cnt_i (frame_cnt),
    .enable_o    (enable),
    .presc_o     (presc),
    .res_shift_o (res_shift),
    .mode_o      (mode),
    .color0_o    (color0),
    .color1_o    (color1)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FPORCH (H_FPORCH),
    .H_SYNC   (H_SYNC),
    .H_BPORCH (H_BPORCH),
    .V_ACTIVE (V_ACTIVE),
    .V_FPORCH (V_FPORCH),
    .V_SYNC   (V_SYNC),
    .V_BPORCH (V_BPORCH)
  ) vga_timing_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .enable_i    (enable),
    .presc_i     (presc),
    .res_shift_i (res_shift),
    .active_o    (active),
    .x_o         (x),
    .y_o         (y),
    .hsync_n_o   (hsync_n),
    .vsync_n_o   (vsync_n),
    .vblank_o    (vblank),
    .frame_cnt_o (frame_cnt)
  );

  vga_pixel_out vga_pixel_out_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .enable_i  (enable),
    .mode_i    (mode),
    .color0_i  (color0),
    .color1_i  (color1),
    .active_i  (active),
    .x_i       (x),
    .y_i       (y),
    .hsync_n_i (hsync_n),
    .vsync_n_i (vsync_n),
    .pixel_o   (pixel_o),
    .hsync_o   (hsync_o),
    .vsync_o   (vsync_o)
  );

endmodule

/* test/vga_top_tb.sv */
`timescale 1ns/10ps

module vga_top_tb;

  // Small geometry keeps a frame at 288 positions
  localparam int H_ACTIVE  = 16;
  localparam int H_FPORCH  = 2;
  localparam int H_SYNC    = 3;
  localparam int H_BPORCH  = 3;
  localparam int V_ACTIVE  = 8;
  localparam int V_FPORCH  = 1;
  localparam int V_SYNC    = 2;
  localparam int V_BPORCH  = 1;
  localparam int H_TOTAL   = H_ACTIVE + H_FPORCH + H_SYNC + H_BPORCH;
  localparam int V_TOTAL   = V_ACTIVE + V_FPORCH + V_SYNC + V_BPORCH;
  localparam int FRAME_POS = H_TOTAL * V_TOTAL;
  localparam int BUS_CLKS  = 20; // Allowance per bus op
  localparam int IDLE_CLKS = 50;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wbs_cyc_i;
  logic        wbs_stb_i;
  logic        wbs_we_i;
  logic [3:0]  wbs_sel_i;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic        wbs_ack_o;
  logic [31:0] wbs_dat_o;
  logic [7:0]  pixel_o;
  logic        hsync_o;
  logic        vsync_o;

  int          clk_cnt = 0;   // Rising edges so far
  int          budget  = 100; // Watchdog limit that grows with every step
  logic [31:0] ctrl_q  = '0;  // CTRL as the testbench wrote it
  int          en_cnt  = 0;   // clk_cnt right after the enabling ack edge
  int          presc_m = 0;
  int          last_n  = -1;  // Last sampled linear position

  vga_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FPORCH (H_FPORCH),
    .H_SYNC   (H_SYNC),
    .H_BPORCH (H_BPORCH),
    .V_ACTIVE (V_ACTIVE),
    .V_FPORCH (V_FPORCH),
    .V_SYNC   (V_SYNC),
    .V_BPORCH (V_BPORCH)
  ) vga_top_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o),
    .pixel_o   (pixel_o),
    .hsync_o   (hsync_o),
    .vsync_o   (vsync_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i; // 4 ns period
  end

  always @(posedge wb_clk_i) clk_cnt <= clk_cnt + 1;

  // Watchdog
  initial begin
    while (clk_cnt <= budget) begin
      @(posedge wb_clk_i);
    end
    $display("timeout, display did not reach the sample point");
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic bad_vectors(input string why);
    $display("vector file problem: %s", why);
    $display("=== FAIL ===");
    $fatal(1, "bad vector file");
  endtask

  function automatic logic [31:0] byte_mask(input logic [3:0] sel);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  // Linear position shown at the pins after the edge counted as c
  function automatic int model_pos(input int c);
    return (c - en_cnt - 1) / (presc_m + 1);
  endfunction

  task automatic wait_ack();
    do begin
      @(posedge wb_clk_i);
      #1;
    end while (!wbs_ack_o);
  endtask

  task automatic bus_write(input int idx, input logic [3:0] sel, input logic [31:0] data);
    budget    = budget + BUS_CLKS;
    wbs_adr_i = 32'(idx) << 2;
    wbs_sel_i = sel;
    wbs_dat_i = data;
    wbs_we_i  = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wait_ack(); // Register updated on this ack edge
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic bus_read(input int idx, output logic [31:0] data);
    budget    = budget + BUS_CLKS;
    wbs_adr_i = 32'(idx) << 2;
    wbs_sel_i = 4'hf;
    wbs_we_i  = 1'b0;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wait_ack();
    data      = wbs_dat_o; // Valid only while ack is high
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
  endtask

  task automatic idle_check(input string name);
    budget = budget + IDLE_CLKS + 10;
    repeat (IDLE_CLKS) begin
      @(posedge wb_clk_i);
      #1;
      check({name, " hsync"}, 32'd1, {31'd0, hsync_o});
      check({name, " vsync"}, 32'd1, {31'd0, vsync_o});
      check({name, " pixel"}, 32'd0, {24'd0, pixel_o});
      check({name, " ack"}, 32'd0, {31'd0, wbs_ack_o});
      check({name, " read data"}, 32'd0, wbs_dat_o); // Bus data is zero without ack
    end
  endtask

  // Mirror CTRL and start the model on enable or check idle on disable
  task automatic update_ctrl(input logic [3:0] sel, input logic [31:0] data);
    logic [31:0] mask;
    logic        was_en;
    mask   = byte_mask(sel);
    was_en = ctrl_q[0];
    ctrl_q = (ctrl_q & ~mask) | (data & mask);
    if (ctrl_q[0] && !was_en) begin
      en_cnt  = clk_cnt;
      presc_m = int'(ctrl_q[7:4]);
      last_n  = -1;
      budget  = budget + 3 * FRAME_POS * (presc_m + 1); // Three frames per section
    end else if (!ctrl_q[0] && was_en) begin
      idle_check("idle after disable");
    end
  endtask

  // Follow the model clock by clock and check both syncs on every step
  task automatic wait_sample(input int x, input int y, input logic [7:0] exp);
    int   n;
    int   h;
    int   v;
    logic hs;
    logic vs;
    bit   hit;
    hit = 1'b0;
    while (!hit) begin
      @(posedge wb_clk_i);
      #1;
      n  = model_pos(clk_cnt);
      h  = n % H_TOTAL;
      v  = (n / H_TOTAL) % V_TOTAL;
      hs = !(h >= H_ACTIVE + H_FPORCH && h < H_ACTIVE + H_FPORCH + H_SYNC); // Active low
      vs = !(v >= V_ACTIVE + V_FPORCH && v < V_ACTIVE + V_FPORCH + V_SYNC);
      check($sformatf("hsync at %0d,%0d", h, v), {31'd0, hs}, {31'd0, hsync_o});
      check($sformatf("vsync at %0d,%0d", h, v), {31'd0, vs}, {31'd0, vsync_o});
      if (n > last_n && h == x && v == y) begin
        check($sformatf("pixel at %0d,%0d", x, y), {24'd0, exp}, {24'd0, pixel_o});
        last_n = n;
        hit    = 1'b1;
      end
    end
  endtask

  initial begin : main
    int          fd;
    int          code;
    int          rec;
    int          idx;
    int          px;
    int          py;
    string       kind;
    string       rest;
    logic [3:0]  sel;
    logic [31:0] data;
    logic [31:0] rd;
    wb_rst_i  = 1'b1;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_sel_i = 4'h0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    rec       = 0;
    repeat (3) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    idle_check("idle after reset");

    fd = $fopen("test/vga_vectors.txt", "r");
    if (fd == 0) begin
      bad_vectors("cannot open test/vga_vectors.txt");
    end
    while ($fscanf(fd, "%s", kind) == 1) begin
      rec = rec + 1;
      if (kind.substr(0, 0) == "#") begin
        code = $fgets(rest, fd); // Rest of the comment line
      end else if (kind == "W") begin
        code = $fscanf(fd, "%d %h %h", idx, sel, data);
        if (code != 3) bad_vectors($sformatf("short write at entry %0d", rec));
        bus_write(idx, sel, data);
        if (idx == 0) update_ctrl(sel, data);
      end else if (kind == "R") begin
        code = $fscanf(fd, "%d %h", idx, data);
        if (code != 2) bad_vectors($sformatf("short read at entry %0d", rec));
        bus_read(idx, rd);
        check($sformatf("read index %0d entry %0d", idx, rec), data, rd);
      end else if (kind == "P") begin
        code = $fscanf(fd, "%d %d %h", px, py, data);
        if (code != 3) bad_vectors($sformatf("short sample at entry %0d", rec));
        wait_sample(px, py, data[7:0]);
      end else begin
        bad_vectors($sformatf("unknown line type %s", kind));
      end
    end
    $fclose(fd);
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* vga_top.f */
hw/vga_pkg.sv
hw/vga_wb_regs.sv
hw/vga_timing.sv
hw/vga_pixel_out.sv
hw/vga_top.sv
test/vga_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the VGA controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module vga_top_tb -f vga_top.f -o vga_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/vga_sim 2>&1)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
fi
echo "pass message not found"
exit 1

/* test/vga_vectors.txt */
# W index sel data : bus write, sel and data in hex
# R index data : read with expected data / P x y color : pixel at base coordinates
# Register access with the display off
W 0 f 00001320
R 0 00001220
W 0 2 00000100
R 0 00000120
W 1 f 0000a55a
R 1 0000a55a
W 1 2 ffff3cff
R 1 00003c5a
W 2 f ffffffff
R 2 00000000
W 3 f 12345678
R 3 00000000
W 0 f 00000000
# Fill mode with prescaler 0
W 1 f 00000025
W 0 f 00000001
P 0 0 25
P 15 0 25
P 16 0 00
P 19 0 00
P 23 3 00
P 7 7 25
P 4 9 00
P 20 10 00
W 0 f 00000000
# Fill mode with prescaler 2 after a single byte color write
W 1 1 000000e3
R 1 000000e3
W 0 f 00000021
P 3 1 e3
P 17 2 00
P 12 9 00
P 2 10 00
W 0 f 00000000
# Checkerboard at full resolution
W 1 f 0000c318
W 0 f 00001001
P 0 0 18
P 2 0 c3
P 5 1 18
P 6 2 18
P 9 3 c3
P 14 6 18
P 17 6 00
W 0 f 00000000
# Checkerboard with halved coordinates and prescaler 1
W 0 f 00001111
P 1 0 18
P 4 1 c3
P 7 2 c3
P 8 5 c3
P 13 6 18
P 10 7 c3
W 0 f 00000000
# Frame count and vblank after two full frames
W 0 f 00000011
P 5 3 18
P 5 3 18
P 5 3 18
P 0 10 00
R 2 00020001
W 0 f 00000000
R 2 00020000
